//--- src/exec_pkg.sv
// exec_pkg
// widths, uop codes and message formats shared by the decode and
// execute stages

package exec_pkg;

  // pc and operand widths
  localparam int addr_bits = 32;
  localparam int data_bits = 32;

  //--------------------------------------------------------------------------
  // micro-op codes
  //--------------------------------------------------------------------------

  // alu ops first, then control ops
  typedef enum logic [3:0] {
    add    = 4'd0,
    sub    = 4'd1,
    and_op = 4'd2,
    or_op  = 4'd3,
    xor_op = 4'd4,
    sll    = 4'd5,
    srl    = 4'd6,
    slt    = 4'd7,
    beq    = 4'd8,
    bne    = 4'd9,
    jal    = 4'd10
  } rv_uop;

  //--------------------------------------------------------------------------
  // stage messages
  //--------------------------------------------------------------------------

  // decoded op handed from decode to execute
  typedef struct packed {
    logic [addr_bits-1:0] pc;
    logic [data_bits-1:0] op1;
    logic [data_bits-1:0] op2;
    logic [data_bits-1:0] imm;
    logic           [4:0] waddr;
    rv_uop                uop;
  } d_x_msg;

  // result leaving execute toward writeback
  typedef struct packed {
    logic [addr_bits-1:0] pc;
    logic           [4:0] waddr;
    logic [data_bits-1:0] wdata;
  } x_w_msg;

endpackage

//--- src/d_x_intf.sv
// d_x_intf
// decode-to-execute link with a valid/ready op stream forward and the
// branch squash and target coming back

`timescale 1ns/1ns

interface d_x_intf;

  // forward op stream, decode drives val and msg
  logic              val;
  logic              rdy;
  exec_pkg::d_x_msg  msg;

  // backward redirect from execute
  // squash is a single-cycle pulse
  logic                           squash;
  logic [exec_pkg::addr_bits-1:0] branch_target;

  // decode side of the link
  modport d_side (
    output val,
    output msg,
    input  rdy,
    input  squash,
    input  branch_target
  );

  // execute side of the link
  modport x_side (
    input  val,
    input  msg,
    output rdy,
    output squash,
    output branch_target
  );

endinterface

//--- src/msg_fifo.sv
// msg_fifo
// valid/ready circular queue for any packed payload
// flush empties it in one cycle and wins over a same-cycle enqueue

`timescale 1ns/1ns

module msg_fifo #(
  parameter int  p_depth = 2,
  parameter type t_msg   = logic [31:0]
) (
  input  logic clk,
  input  logic reset,
  input  logic flush,

  input  logic enq_val,
  output logic enq_rdy,
  input  t_msg enq_msg,

  output logic deq_val,
  input  logic deq_rdy,
  output t_msg deq_msg
);

  // pointer needs at least one bit even for a single entry
  localparam int ptr_bits = (p_depth > 1) ? $clog2(p_depth) : 1;
  localparam int cnt_bits = $clog2(p_depth + 1);

  t_msg                entries [p_depth];
  logic [ptr_bits-1:0] head;
  logic [ptr_bits-1:0] tail;
  logic [cnt_bits-1:0] count;
  logic                live;
  logic                do_enq;
  logic                do_deq;

  // wrap at the last slot
  function automatic logic [ptr_bits-1:0] next_ptr(input logic [ptr_bits-1:0] ptr);
    logic [ptr_bits-1:0] nxt;
    if (ptr == ptr_bits'(p_depth - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  // live rises one cycle after reset drops
  always_ff @(posedge clk) begin
    if (reset) begin
      live <= 1'b0;
    end else begin
      live <= 1'b1;
    end
  end

  assign enq_rdy = live && (count != cnt_bits'(p_depth));
  assign deq_val = (count != '0);
  assign deq_msg = entries[head];
  assign do_enq  = enq_val & enq_rdy;
  assign do_deq  = deq_val & deq_rdy;

  // payload storage
  always_ff @(posedge clk) begin
    if (do_enq) begin
      entries[tail] <= enq_msg;
    end
  end

  // pointers and occupancy, flush drops everything
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (do_enq) begin
        tail <= next_ptr(tail);
      end
      if (do_deq) begin
        head <= next_ptr(head);
      end
      case ({do_enq, do_deq})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- src/decode_issue.sv
// decode_issue
// queues decoded ops ahead of execute and presents them on d_x_intf
// a squash from execute flushes every op still waiting

`timescale 1ns/1ns

module decode_issue #(
  parameter int p_issue_depth = 4
) (
  input  logic             clk,
  input  logic             reset,

  // decoded op stream from the front end
  input  logic             in_val,
  output logic             in_rdy,
  input  exec_pkg::d_x_msg in_msg,

  d_x_intf.d_side          dx
);

  logic q_enq_rdy;
  logic q_enq_val;

  //--------------------------------------------------------------------------
  // input side
  //--------------------------------------------------------------------------

  // hold off new ops during the squash cycle
  // otherwise an accepted op would vanish in the flush
  assign in_rdy    = q_enq_rdy & ~dx.squash;
  assign q_enq_val = in_val & ~dx.squash;

  //--------------------------------------------------------------------------
  // issue queue
  //--------------------------------------------------------------------------

  // everything queued is younger than the branch, so squash clears it all
  // wrong-path ops already handed over are dropped inside execute
  msg_fifo #(
    .p_depth (p_issue_depth),
    .t_msg   (exec_pkg::d_x_msg)
  ) issue_q (
    .clk     (clk),
    .reset   (reset),
    .flush   (dx.squash),

    .enq_val (q_enq_val),
    .enq_rdy (q_enq_rdy),
    .enq_msg (in_msg),

    // head of queue drives the link directly
    .deq_val (dx.val),
    .deq_rdy (dx.rdy),
    .deq_msg (dx.msg)
  );

endmodule

//--- src/execute_unit.sv
// execute_unit
// alu and branch resolution for ops from d_x_intf
// taken branches squash decode and skip wrong-path ops until the target

`timescale 1ns/1ns

module execute_unit #(
  parameter int p_wb_depth = 2
) (
  input  logic                           clk,
  input  logic                           reset,

  d_x_intf.x_side                        dx,

  // result stream
  output logic                           wb_val,
  input  logic                           wb_rdy,
  output exec_pkg::x_w_msg               wb_msg,

  // redirect pulse toward fetch
  output logic                           redirect_val,
  output logic [exec_pkg::addr_bits-1:0] redirect_pc
);

  exec_pkg::d_x_msg               op;
  logic                           accept;
  logic                           exec_op;
  logic                           writes;
  logic                           taken;
  logic [exec_pkg::data_bits-1:0] result;
  logic [exec_pkg::addr_bits-1:0] target;
  logic                           skip;
  logic                           squash_q;
  logic [exec_pkg::addr_bits-1:0] target_q;
  logic                           wb_enq_val;
  logic                           wb_enq_rdy;
  exec_pkg::x_w_msg               wb_enq_msg;

  assign op = dx.msg;

  // stall while squash is out so redirects never come back to back
  assign dx.rdy  = wb_enq_rdy & ~squash_q;
  assign accept  = dx.val & dx.rdy;
  // in skip mode only the target pc gets through
  assign exec_op = accept & (~skip | (op.pc == target_q));

  //--------------------------------------------------------------------------
  // alu and branch compare
  //--------------------------------------------------------------------------

  always_comb begin
    result = '0;
    writes = 1'b1;
    taken  = 1'b0;
    target = op.pc + op.imm;
    case (op.uop)
      exec_pkg::add:    result = op.op1 + op.op2;
      exec_pkg::sub:    result = op.op1 - op.op2;
      exec_pkg::and_op: result = op.op1 & op.op2;
      exec_pkg::or_op:  result = op.op1 | op.op2;
      exec_pkg::xor_op: result = op.op1 ^ op.op2;
      // shift amount from low 5 bits only
      exec_pkg::sll:    result = op.op1 << op.op2[4:0];
      exec_pkg::srl:    result = op.op1 >> op.op2[4:0];
      exec_pkg::slt:    result[0] = $signed(op.op1) < $signed(op.op2);
      exec_pkg::beq: begin
        writes = 1'b0;
        taken  = (op.op1 == op.op2);
      end
      exec_pkg::bne: begin
        writes = 1'b0;
        taken  = (op.op1 != op.op2);
      end
      // link value is pc+4, target comes in op1
      exec_pkg::jal: begin
        result = op.pc + 32'd4;
        taken  = 1'b1;
        target = op.op1;
      end
      default:          writes = 1'b0;
    endcase
  end

  //--------------------------------------------------------------------------
  // redirect and wrong-path skip
  //--------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      skip     <= 1'b0;
      squash_q <= 1'b0;
    end else begin
      squash_q <= exec_op & taken;
      if (exec_op & taken) begin
        skip <= 1'b1;
      end else if (exec_op) begin
        // target reached or no skip pending
        skip <= 1'b0;
      end
    end
  end

  // target doubles as redirect pc and skip match
  always_ff @(posedge clk) begin
    if (exec_op & taken) begin
      target_q <= target;
    end
  end

  assign dx.squash        = squash_q;
  assign dx.branch_target = target_q;
  assign redirect_val     = squash_q;
  assign redirect_pc      = target_q;

  //--------------------------------------------------------------------------
  // writeback queue
  //--------------------------------------------------------------------------

  assign wb_enq_val       = exec_op & writes;
  assign wb_enq_msg.pc    = op.pc;
  assign wb_enq_msg.waddr = op.waddr;
  assign wb_enq_msg.wdata = result;

  // results are committed once queued, nothing to flush here
  msg_fifo #(
    .p_depth (p_wb_depth),
    .t_msg   (exec_pkg::x_w_msg)
  ) wb_q (
    .clk     (clk),
    .reset   (reset),
    .flush   (1'b0),
    .enq_val (wb_enq_val),
    .enq_rdy (wb_enq_rdy),
    .enq_msg (wb_enq_msg),
    .deq_val (wb_val),
    .deq_rdy (wb_rdy),
    .deq_msg (wb_msg)
  );

endmodule

//--- src/exec_top.sv
// exec_top
// decode-to-execute slice of the core, decode_issue feeding
// execute_unit over d_x_intf with plain ports outside

`timescale 1ns/1ns

module exec_top #(
  parameter int p_issue_depth = 4,
  parameter int p_wb_depth    = 2
) (
  input  logic                           clk,
  input  logic                           reset,

  // decoded ops in
  input  logic                           in_val,
  output logic                           in_rdy,
  input  logic [exec_pkg::addr_bits-1:0] in_pc,
  input  logic [exec_pkg::data_bits-1:0] in_op1,
  input  logic [exec_pkg::data_bits-1:0] in_op2,
  input  logic [exec_pkg::data_bits-1:0] in_imm,
  input  logic                     [4:0] in_waddr,
  input  exec_pkg::rv_uop                in_uop,

  // results out
  output logic                           wb_val,
  input  logic                           wb_rdy,
  output logic [exec_pkg::addr_bits-1:0] wb_pc,
  output logic                     [4:0] wb_waddr,
  output logic [exec_pkg::data_bits-1:0] wb_wdata,

  // branch redirect, same pulse as squash
  output logic                           redirect_val,
  output logic [exec_pkg::addr_bits-1:0] redirect_pc
);

  exec_pkg::d_x_msg in_msg;
  exec_pkg::x_w_msg wb_msg;

  d_x_intf dx ();

  // pack input fields
  assign in_msg.pc    = in_pc;
  assign in_msg.op1   = in_op1;
  assign in_msg.op2   = in_op2;
  assign in_msg.imm   = in_imm;
  assign in_msg.waddr = in_waddr;
  assign in_msg.uop   = in_uop;

  decode_issue #(
    .p_issue_depth (p_issue_depth)
  ) decode_issue_inst (
    .clk    (clk),
    .reset  (reset),
    .in_val (in_val),
    .in_rdy (in_rdy),
    .in_msg (in_msg),
    .dx     (dx.d_side)
  );

  execute_unit #(
    .p_wb_depth (p_wb_depth)
  ) execute_unit_inst (
    .clk          (clk),
    .reset        (reset),
    .dx           (dx.x_side),
    .wb_val       (wb_val),
    .wb_rdy       (wb_rdy),
    .wb_msg       (wb_msg),
    .redirect_val (redirect_val),
    .redirect_pc  (redirect_pc)
  );

  // unpack result fields
  assign wb_pc    = wb_msg.pc;
  assign wb_waddr = wb_msg.waddr;
  assign wb_wdata = wb_msg.wdata;

endmodule

//--- verif/exec_asserts.sv
// exec_asserts
// handshake stability, redirect pulse width and reset state checks
// on the exec_top ports and the d_x link

`timescale 1ns/1ns

module exec_asserts (
  input logic                           clk,
  input logic                           reset,
  input logic                           in_rdy,
  input logic                           wb_val,
  input logic                           wb_rdy,
  input logic [exec_pkg::addr_bits-1:0] wb_pc,
  input logic                     [4:0] wb_waddr,
  input logic [exec_pkg::data_bits-1:0] wb_wdata,
  input logic                           redirect_val,
  input logic                           dx_val,
  input logic                           dx_rdy,
  input logic                           dx_squash,
  input exec_pkg::d_x_msg               dx_msg
);

  // result held until the sink takes it
  wb_hold: assert property (@(posedge clk) disable iff (reset)
    wb_val && !wb_rdy |=> wb_val && $stable(wb_pc) && $stable(wb_waddr) && $stable(wb_wdata))
    else $error("wb stream changed while stalled");

  // link op held under stall, a squash may flush it
  dx_hold: assert property (@(posedge clk) disable iff (reset)
    dx_val && !dx_rdy && !dx_squash |=> dx_val && $stable(dx_msg))
    else $error("d_x op changed while stalled");

  // redirect is a single-cycle pulse
  redirect_pulse: assert property (@(posedge clk) disable iff (reset)
    redirect_val |=> !redirect_val)
    else $error("redirect held for two cycles");

  // control outputs quiet after every reset edge
  reset_quiet: assert property (@(posedge clk)
    reset |=> !in_rdy && !wb_val && !redirect_val && !dx_val && !dx_squash)
    else $error("control output high during reset");

endmodule

bind exec_top exec_asserts exec_asserts_inst (
  .clk          (clk),
  .reset        (reset),
  .in_rdy       (in_rdy),
  .wb_val       (wb_val),
  .wb_rdy       (wb_rdy),
  .wb_pc        (wb_pc),
  .wb_waddr     (wb_waddr),
  .wb_wdata     (wb_wdata),
  .redirect_val (redirect_val),
  .dx_val       (dx.val),
  .dx_rdy       (dx.rdy),
  .dx_squash    (dx.squash),
  .dx_msg       (dx.msg)
);

//--- verif/exec_tb.sv
// exec_tb
// random op stream through exec_top with back-pressure, checked against
// a program-order model of the alu, branch and wrong-path rules

`timescale 1ns/1ns

module exec_tb;

  localparam int n_ops          = 400;
  localparam int timeout_cycles = n_ops * 20;

  logic                           clk;
  logic                           reset;
  logic                           in_val;
  logic                           in_rdy;
  logic [exec_pkg::addr_bits-1:0] in_pc;
  logic [exec_pkg::data_bits-1:0] in_op1;
  logic [exec_pkg::data_bits-1:0] in_op2;
  logic [exec_pkg::data_bits-1:0] in_imm;
  logic                     [4:0] in_waddr;
  exec_pkg::rv_uop                in_uop;
  logic                           wb_val;
  logic                           wb_rdy;
  logic [exec_pkg::addr_bits-1:0] wb_pc;
  logic                     [4:0] wb_waddr;
  logic [exec_pkg::data_bits-1:0] wb_wdata;
  logic                           redirect_val;
  logic [exec_pkg::addr_bits-1:0] redirect_pc;

  // op stream with the redirect count each op waits for, and expected outputs
  exec_pkg::d_x_msg               ops [$];
  int                             gate [$];
  exec_pkg::x_w_msg               wb_exp [$];
  logic [exec_pkg::addr_bits-1:0] redir_exp [$];
  int                             redirects_seen = 0;
  int                             sent = 0;
  int                             cycles = 0;
  logic                           pending;

  exec_top #(
    .p_issue_depth (4),
    .p_wb_depth    (2)
  ) exec_top_inst (
    .clk          (clk),
    .reset        (reset),
    .in_val       (in_val),
    .in_rdy       (in_rdy),
    .in_pc        (in_pc),
    .in_op1       (in_op1),
    .in_op2       (in_op2),
    .in_imm       (in_imm),
    .in_waddr     (in_waddr),
    .in_uop       (in_uop),
    .wb_val       (wb_val),
    .wb_rdy       (wb_rdy),
    .wb_pc        (wb_pc),
    .wb_waddr     (wb_waddr),
    .wb_wdata     (wb_wdata),
    .redirect_val (redirect_val),
    .redirect_pc  (redirect_pc)
  );

  always #10 clk = ~clk;

  // --------------------------------------------------------------------------
  // reference model
  // --------------------------------------------------------------------------

  function automatic logic [exec_pkg::data_bits-1:0] result_model(input exec_pkg::d_x_msg m);
    logic [exec_pkg::data_bits-1:0] r;
    case (m.uop)
      exec_pkg::add:    r = m.op1 + m.op2;
      exec_pkg::sub:    r = m.op1 - m.op2;
      exec_pkg::and_op: r = m.op1 & m.op2;
      exec_pkg::or_op:  r = m.op1 | m.op2;
      exec_pkg::xor_op: r = m.op1 ^ m.op2;
      exec_pkg::sll:    r = m.op1 << m.op2[4:0];
      exec_pkg::srl:    r = m.op1 >> m.op2[4:0];
      exec_pkg::slt:    r = ($signed(m.op1) < $signed(m.op2)) ? 32'd1 : 32'd0;
      // link address
      exec_pkg::jal:    r = m.pc + 32'd4;
      default:          r = '0;
    endcase
    return r;
  endfunction

  function automatic logic taken_model(input exec_pkg::d_x_msg m);
    return (m.uop == exec_pkg::jal) ||
           (m.uop == exec_pkg::beq && m.op1 == m.op2) ||
           (m.uop == exec_pkg::bne && m.op1 != m.op2);
  endfunction

  // jal jumps to op1 and conditional branches to pc+imm
  function automatic logic [exec_pkg::addr_bits-1:0] target_model(input exec_pkg::d_x_msg m);
    return (m.uop == exec_pkg::jal) ? m.op1 : m.pc + m.imm;
  endfunction

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------

  function automatic exec_pkg::d_x_msg random_op(input logic [exec_pkg::addr_bits-1:0] pc,
                                                 input logic control);
    exec_pkg::d_x_msg               m;
    logic [exec_pkg::addr_bits-1:0] offset;
    m.pc    = pc;
    m.op1   = $urandom();
    m.op2   = $urandom();
    m.imm   = $urandom();
    m.waddr = 5'($urandom_range(31));
    m.uop   = exec_pkg::rv_uop'(4'($urandom_range(7)));
    if (control) begin
      m.uop = exec_pkg::rv_uop'(4'(8 + $urandom_range(2)));
      // forward beyond any wrong-path pc or backward
      if ($urandom_range(1) == 0) begin
        offset = 32'd16 + 32'd4 * $urandom_range(15);
      end else begin
        offset = 32'd0 - 32'd4 * (1 + $urandom_range(15));
      end
      m.imm = offset;
      if (m.uop == exec_pkg::jal) begin
        m.op1 = pc + offset;
      end else if ($urandom_range(1) == 0) begin
        // equal operands half the time
        m.op2 = m.op1;
      end
    end
    return m;
  endfunction

  // program order walk with wrong-path ops after each taken branch
  task automatic build_stream();
    exec_pkg::d_x_msg               m;
    exec_pkg::x_w_msg               w;
    logic [exec_pkg::addr_bits-1:0] pc;
    int                             taken_cnt;
    int                             n_wrong;
    int                             k;
    pc        = 32'h0000_1000;
    taken_cnt = 0;
    while (ops.size() < n_ops) begin
      m = random_op(pc, $urandom_range(99) >= 70);
      ops.push_back(m);
      gate.push_back(taken_cnt);
      if (m.uop != exec_pkg::beq && m.uop != exec_pkg::bne) begin
        w.pc    = m.pc;
        w.waddr = m.waddr;
        w.wdata = result_model(m);
        wb_exp.push_back(w);
      end
      if (taken_model(m)) begin
        redir_exp.push_back(target_model(m));
        taken_cnt++;
        n_wrong = $urandom_range(3);
        for (k = 1; k <= n_wrong && ops.size() < n_ops; k++) begin
          ops.push_back(random_op(pc + 32'(4 * k), 1'b0));
          // may go out before the redirect is seen
          gate.push_back(taken_cnt - 1);
        end
        pc = target_model(m);
      end else begin
        pc = pc + 32'd4;
      end
    end
  endtask

  task automatic apply_op(input exec_pkg::d_x_msg m);
    in_pc    = m.pc;
    in_op1   = m.op1;
    in_op2   = m.op2;
    in_imm   = m.imm;
    in_waddr = m.waddr;
    in_uop   = m.uop;
  endtask

  // --------------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------------

  task automatic end_with_failure();
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    $display("Error: %s is %h, expected %h", name, got, exp);
    end_with_failure();
  endtask

  task automatic compare_wb(input exec_pkg::x_w_msg got, input exec_pkg::x_w_msg exp);
    if (got.pc !== exp.pc) begin
      report_value("wb_pc", got.pc, exp.pc);
    end else if (got.waddr !== exp.waddr) begin
      report_value("wb_waddr", 32'(got.waddr), 32'(exp.waddr));
    end else if (got.wdata !== exp.wdata) begin
      report_value("wb_wdata", got.wdata, exp.wdata);
    end
  endtask

  task automatic compare_redirect(input logic [exec_pkg::addr_bits-1:0] got,
                                  input logic [exec_pkg::addr_bits-1:0] exp);
    if (got !== exp) begin
      report_value("redirect_pc", got, exp);
    end
  endtask

  always @(negedge clk) begin : wb_monitor
    exec_pkg::x_w_msg got;
    if (!reset && wb_val && wb_rdy) begin
      got.pc    = wb_pc;
      got.waddr = wb_waddr;
      got.wdata = wb_wdata;
      if (wb_exp.size() == 0) begin
        $display("writeback at pc %h with no result left in the model", wb_pc);
        end_with_failure();
      end else begin
        compare_wb(got, wb_exp.pop_front());
      end
    end
  end

  always @(negedge clk) begin : redirect_monitor
    if (!reset && redirect_val) begin
      if (redir_exp.size() == 0) begin
        $display("redirect to %h with no taken branch left in the model", redirect_pc);
        end_with_failure();
      end else begin
        redirects_seen++;
        compare_redirect(redirect_pc, redir_exp.pop_front());
      end
    end
  end

  always @(posedge clk) begin : watchdog
    cycles++;
    if (cycles >= timeout_cycles) begin
      $display("timeout after %0d cycles with %0d of %0d ops sent", cycles, sent, n_ops);
      end_with_failure();
    end
  end

  // sink back-pressure at 70% ready
  always @(posedge clk) begin
    #2;
    wb_rdy = ($urandom_range(99) < 70);
  end

  initial begin : stimulus
    clk    = 1'b0;
    reset  = 1'b1;
    wb_rdy = 1'b0;
    in_val = 1'b0;
    apply_op('0);
    pending = 1'b0;
    void'($urandom(32'ha375a290));
    build_stream();
    repeat (3) @(posedge clk);
    #2;
    reset = 1'b0;

    // offer ops at 70% and hold an offered op until taken
    while (sent < ops.size()) begin
      @(posedge clk);
      #2;
      if (!pending) begin
        in_val = 1'b0;
        if (redirects_seen >= gate[sent] && $urandom_range(99) < 70) begin
          apply_op(ops[sent]);
          in_val  = 1'b1;
          pending = 1'b1;
        end
      end
      @(negedge clk);
      if (pending && in_rdy) begin
        sent++;
        pending = 1'b0;
      end
    end
    @(posedge clk);
    #2;
    in_val = 1'b0;

    // drain then look for stray results
    while (wb_exp.size() != 0 || redir_exp.size() != 0) begin
      @(posedge clk);
    end
    repeat (10) @(posedge clk);
    if (!wb_val) begin
      $display("Test passed");
      $finish;
    end else begin
      $display("writeback still pending after the last expected result");
      end_with_failure();
    end
  end

endmodule

//--- project.f
src/exec_pkg.sv
src/d_x_intf.sv
src/msg_fifo.sv
src/decode_issue.sv
src/execute_unit.sv
src/exec_top.sv
verif/exec_asserts.sv
verif/exec_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the exec_top testbench with verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module exec_tb -f project.f \
  && ./obj_dir/Vexec_tb 2>&1 | tee sim.log \
  || { echo "build or simulation did not complete"; exit 1; }

grep -q "Test failed" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q "Test passed" sim.log || { echo "no pass line found in sim.log"; exit 1; }
echo "simulation clean"
exit 0
